//--- logic/zx_pkg.sv
package zx_pkg;

	// ========================================================================
	// Bus and memory types
	// ========================================================================

	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  cpu_data_t;

	// ROM flag, 5-bit bank number, 14-bit offset
	typedef logic [19:0] mem_addr_t;
	typedef logic [4:0]  bank_t;

	typedef logic [2:0]  border_t;

	// Eight half-rows of five keys, active low
	typedef logic [39:0] key_matrix_t;

	typedef enum logic [1:0] {
		MEM_128K = 2'd0,
		MEM_512K = 2'd1,
		MEM_48K  = 2'd2
	} mem_mode_t;

	// Width of the offset inside a 16K bank
	localparam int BANK_OFFSET_W = 14;

	// Banks that are always mapped at 4000 and 8000
	localparam bank_t PAGE_BANK_5 = 5'd5;
	localparam bank_t PAGE_BANK_2 = 5'd2;

	// ========================================================================
	// Port constants
	// ========================================================================

	// Bits of the 7FFD paging byte
	localparam int PAGE_SCR_BIT  = 3;
	localparam int PAGE_ROM_BIT  = 4;
	localparam int PAGE_LOCK_BIT = 5;

	// Bits of the FE output byte, border is 2:0
	localparam int ULA_MIC_BIT = 3;
	localparam int ULA_EAR_BIT = 4;

	// Keyboard layout as seen through port FE
	localparam int KEY_ROWS  = 8;
	localparam int KEY_ROW_W = 5;

endpackage

//--- logic/zx_bus_decode.sv
`timescale 1ns/1ps

module zx_bus_decode (
	input  logic             clk_sys,
	input  logic             reset,
	input  zx_pkg::cpu_addr_t addr,
	input  logic             m1_n,
	input  logic             iorq_n,
	input  logic             rd_n,
	input  logic             wr_n,
	output logic             io_write,
	output logic             io_read_active,
	output logic             sel_page,
	output logic             sel_ula
);

	logic io_wr;
	logic io_rd;
	logic io_wr_q;

	// IORQ together with M1 is an interrupt acknowledge, not a port access
	assign io_wr = ~iorq_n & ~wr_n & m1_n;
	assign io_rd = ~iorq_n & ~rd_n & m1_n;

	// Previous write level, so a long write strobe counts once
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q <= 1'b0;
		end else begin
			io_wr_q <= io_wr;
		end
	end

	// High up to and including the first edge that samples the write
	assign io_write = io_wr & ~io_wr_q;

	assign io_read_active = io_rd;

	// ========================================================================
	// Port selects
	// ========================================================================

	// 7FFD is partially decoded on A15 and A1
	assign sel_page = ~addr[15] & ~addr[1];

	// Any even port reaches the ULA
	assign sel_ula = ~addr[0];

	// The strobes come from one CPU, so they never overlap
	a_no_rd_wr_overlap : assert property (
		@(posedge clk_sys) disable iff (reset)
		!(io_rd && io_wr)
	) else $error("I/O read and I/O write active together");

endmodule

//--- logic/zx_mem_pager.sv
`timescale 1ns/1ps

module zx_mem_pager (
	input  logic              clk_sys,
	input  logic              reset,
	input  zx_pkg::mem_mode_t mem_mode,
	input  zx_pkg::cpu_addr_t addr,
	input  zx_pkg::cpu_data_t cpu_dout,
	input  logic              mreq_n,
	input  logic              rd_n,
	input  logic              wr_n,
	input  logic              io_write,
	input  logic              sel_page,
	output zx_pkg::mem_addr_t ram_addr,
	output logic              ram_we,
	output logic              ram_rd,
	output logic              screen_page
);

	import zx_pkg::*;

	mem_mode_t                mode_q;
	cpu_data_t                page_reg;
	logic [1:0]               page_ext;
	logic                     page_disable;
	logic                     page_write;
	logic                     rom_page;
	bank_t                    rom_bank;
	bank_t                    ram_bank;
	logic [BANK_OFFSET_W-1:0] offset;

	// ========================================================================
	// Paging register
	// ========================================================================

	// Lock bit or 48K mode freezes the page until the next reset
	assign page_disable = (mode_q == MEM_48K) | page_reg[PAGE_LOCK_BIT];
	assign page_write   = io_write & sel_page & ~page_disable;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			// Machine type is only taken while in reset
			mode_q   <= mem_mode;
			page_reg <= '0;
			page_ext <= '0;
		end else if (page_write) begin
			page_reg <= cpu_dout;
			// Pentagon style 512K uses the two spare top bits
			if (mode_q == MEM_512K) begin
				page_ext <= cpu_dout[7:6];
			end
		end
	end

	assign screen_page = page_reg[PAGE_SCR_BIT];

	// ========================================================================
	// Address mapping
	// ========================================================================

	// 48K machines only know the BASIC ROM
	assign rom_page = (mode_q == MEM_48K) ? 1'b1 : page_reg[PAGE_ROM_BIT];
	assign rom_bank = {4'd0, rom_page};
	assign ram_bank = {page_ext, page_reg[2:0]};
	assign offset   = addr[BANK_OFFSET_W-1:0];

	always_comb begin
		case (addr[15:14])
			2'b00: ram_addr = {1'b1, rom_bank, offset};
			2'b01: ram_addr = {1'b0, PAGE_BANK_5, offset};
			2'b10: ram_addr = {1'b0, PAGE_BANK_2, offset};
			default: ram_addr = {1'b0, ram_bank, offset};
		endcase
	end

	assign ram_rd = ~mreq_n & ~rd_n;

	// ROM window is write protected
	assign ram_we = ~mreq_n & ~wr_n & (addr[15] | addr[14]);

	// ========================================================================
	// Checks
	// ========================================================================

	// Write protect and mapping agree on where ROM lives
	a_no_rom_write : assert property (
		@(posedge clk_sys) disable iff (reset)
		ram_we |-> !ram_addr[19]
	) else $error("Memory write reached the ROM area");

endmodule

//--- logic/zx_ula_port.sv
`timescale 1ns/1ps

module zx_ula_port (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              io_write,
	input  logic              sel_ula,
	input  zx_pkg::cpu_data_t cpu_dout,
	output zx_pkg::border_t   border_color,
	output logic              ear_out,
	output logic              mic_out
);

	import zx_pkg::*;

	logic ula_write;

	// ========================================================================
	// Port FE output latch
	// ========================================================================

	// One pulse per OUT instruction
	assign ula_write = io_write & sel_ula;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border_color <= '0;
			ear_out      <= 1'b0;
			mic_out      <= 1'b0;
		end else if (ula_write) begin
			// Border colour in the low three bits
			border_color <= cpu_dout[2:0];
			// Speaker and tape out
			ear_out      <= cpu_dout[ULA_EAR_BIT];
			mic_out      <= cpu_dout[ULA_MIC_BIT];
		end
	end

endmodule

//--- logic/zx_io_read.sv
`timescale 1ns/1ps

module zx_io_read (
	input  zx_pkg::cpu_addr_t   addr,
	input  logic                mreq_n,
	input  logic                io_read_active,
	input  logic                sel_ula,
	input  zx_pkg::key_matrix_t key_matrix,
	input  logic                ear_in,
	input  zx_pkg::cpu_data_t   ram_rdata,
	output zx_pkg::cpu_data_t   cpu_din
);

	import zx_pkg::*;

	logic [KEY_ROW_W-1:0] key_row;

	// ========================================================================
	// Keyboard half-rows
	// ========================================================================

	// Every half-row with its address line low is ANDed in
	always_comb begin
		key_row = '1;
		for (int r = 0; r < KEY_ROWS; r++) begin
			if (!addr[8 + r]) begin
				key_row = key_row & key_matrix[r * KEY_ROW_W +: KEY_ROW_W];
			end
		end
	end

	// ========================================================================
	// CPU read data
	// ========================================================================

	// Unmapped ports float high on the real bus
	always_comb begin
		if (!mreq_n) begin
			cpu_din = ram_rdata;
		end else if (io_read_active && sel_ula) begin
			cpu_din = {1'b1, ear_in, 1'b1, key_row};
		end else begin
			cpu_din = 8'hff;
		end
	end

endmodule

//--- logic/zx_host_top.sv
`timescale 1ns/1ps

module zx_host_top (
	input  logic                clk_sys,
	input  logic                reset,

	// Z80 bus
	input  zx_pkg::cpu_addr_t   addr,
	input  zx_pkg::cpu_data_t   cpu_dout,
	input  logic                m1_n,
	input  logic                mreq_n,
	input  logic                iorq_n,
	input  logic                rd_n,
	input  logic                wr_n,
	output zx_pkg::cpu_data_t   cpu_din,

	// Banked memory
	output zx_pkg::mem_addr_t   ram_addr,
	output logic                ram_we,
	output logic                ram_rd,
	input  zx_pkg::cpu_data_t   ram_rdata,

	// Machine configuration and inputs
	input  zx_pkg::mem_mode_t   mem_mode,
	input  zx_pkg::key_matrix_t key_matrix,
	input  logic                ear_in,

	// ULA outputs
	output zx_pkg::border_t     border_color,
	output logic                ear_out,
	output logic                mic_out,
	output logic                screen_page
);

	logic io_write;
	logic io_read_active;
	logic sel_page;
	logic sel_ula;

	// ========================================================================
	// Bus decode
	// ========================================================================

	zx_bus_decode i_bus_decode (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.addr           (addr),
		.m1_n           (m1_n),
		.iorq_n         (iorq_n),
		.rd_n           (rd_n),
		.wr_n           (wr_n),
		.io_write       (io_write),
		.io_read_active (io_read_active),
		.sel_page       (sel_page),
		.sel_ula        (sel_ula)
	);

	// ========================================================================
	// Memory paging and ULA port
	// ========================================================================

	zx_mem_pager i_mem_pager (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.mem_mode    (mem_mode),
		.addr        (addr),
		.cpu_dout    (cpu_dout),
		.mreq_n      (mreq_n),
		.rd_n        (rd_n),
		.wr_n        (wr_n),
		.io_write    (io_write),
		.sel_page    (sel_page),
		.ram_addr    (ram_addr),
		.ram_we      (ram_we),
		.ram_rd      (ram_rd),
		.screen_page (screen_page)
	);

	zx_ula_port i_ula_port (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.io_write     (io_write),
		.sel_ula      (sel_ula),
		.cpu_dout     (cpu_dout),
		.border_color (border_color),
		.ear_out      (ear_out),
		.mic_out      (mic_out)
	);

	// Read data back to the CPU
	zx_io_read i_io_read (
		.addr           (addr),
		.mreq_n         (mreq_n),
		.io_read_active (io_read_active),
		.sel_ula        (sel_ula),
		.key_matrix     (key_matrix),
		.ear_in         (ear_in),
		.ram_rdata      (ram_rdata),
		.cpu_din        (cpu_din)
	);

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	input  logic reset_req,
	output logic clk_sys,
	output logic reset
);

	// 4 ns period
	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// Reset spans two rising edges at power up and again on each request
	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clk_sys);
		#1 reset = 1'b0;
		forever begin
			@(posedge reset_req);
			reset = 1'b1;
			repeat (2) @(posedge clk_sys);
			#1 reset = 1'b0;
		end
	end

endmodule

//--- bench/tb_zx_host.sv
`timescale 1ns/1ps

module tb_zx_host;

	import zx_pkg::*;

	// Roughly 150 cycles of tests, with a wide margin on top
	localparam int TEST_CYCLES = 400;
	localparam int MAX_CYCLES  = 5 * TEST_CYCLES;

	logic        clk_sys;
	logic        reset;
	logic        reset_req;
	cpu_addr_t   addr;
	cpu_data_t   cpu_dout;
	cpu_data_t   cpu_din;
	logic        m1_n;
	logic        mreq_n;
	logic        iorq_n;
	logic        rd_n;
	logic        wr_n;
	mem_addr_t   ram_addr;
	logic        ram_we;
	logic        ram_rd;
	cpu_data_t   ram_rdata;
	mem_mode_t   mem_mode;
	key_matrix_t key_matrix;
	logic        ear_in;
	border_t     border_color;
	logic        ear_out;
	logic        mic_out;
	logic        screen_page;

	// Expected paging state
	mem_mode_t exp_mode;
	bank_t     exp_bank;
	logic      exp_rom;
	logic      exp_scr;
	logic      exp_locked;

	cpu_data_t mem_model [0:(1 << 20) - 1];
	int        cycle_count = 0;

	tb_clock i_clock (
		.reset_req (reset_req),
		.clk_sys   (clk_sys),
		.reset     (reset)
	);

	zx_host_top i_dut (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.addr         (addr),
		.cpu_dout     (cpu_dout),
		.m1_n         (m1_n),
		.mreq_n       (mreq_n),
		.iorq_n       (iorq_n),
		.rd_n         (rd_n),
		.wr_n         (wr_n),
		.cpu_din      (cpu_din),
		.ram_addr     (ram_addr),
		.ram_we       (ram_we),
		.ram_rd       (ram_rd),
		.ram_rdata    (ram_rdata),
		.mem_mode     (mem_mode),
		.key_matrix   (key_matrix),
		.ear_in       (ear_in),
		.border_color (border_color),
		.ear_out      (ear_out),
		.mic_out      (mic_out),
		.screen_page  (screen_page)
	);

	// Memory answers whatever address the DUT puts out
	assign ram_rdata = mem_model[ram_addr];

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			abort_run();
		end
	end

	// ========================================================================
	// Compare tasks
	// ========================================================================

	task automatic abort_run();
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_mem_addr(input string name, input mem_addr_t got, input mem_addr_t exp);
		if (got !== exp) begin
			$display("error %s: got %h, expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_data(input string name, input cpu_data_t got, input cpu_data_t exp);
		if (got !== exp) begin
			$display("error %s: got %h, expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_border(input string name, input border_t got, input border_t exp);
		if (got !== exp) begin
			$display("error %s: got %h, expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error %s: got %h, expected %h", name, got, exp);
			abort_run();
		end
	endtask

	// ========================================================================
	// Expected values and bus cycles
	// ========================================================================

	function automatic cpu_data_t rand_byte();
		logic [31:0] r;
		r = $urandom;
		return r[7:0];
	endfunction

	function automatic cpu_addr_t rand_addr();
		logic [31:0] r;
		r = $urandom;
		return r[15:0];
	endfunction

	// ROM flag, bank, offset for each 16K window
	function automatic mem_addr_t exp_map(input cpu_addr_t a);
		case (a[15:14])
			2'b00: return {1'b1, 4'd0, exp_rom, a[13:0]};
			2'b01: return {1'b0, 5'd5, a[13:0]};
			2'b10: return {1'b0, 5'd2, a[13:0]};
			default: return {1'b0, exp_bank, a[13:0]};
		endcase
	endfunction

	// Half-rows whose address line is low are ANDed together
	function automatic cpu_data_t exp_key_byte(input cpu_addr_t a, input key_matrix_t keys,
			input logic ear);
		logic [4:0] row;
		int         r;
		row = 5'h1f;
		for (r = 0; r < 8; r++) begin
			if (!a[8 + r]) begin
				row = row & keys[5 * r +: 5];
			end
		end
		return {1'b1, ear, 1'b1, row};
	endfunction

	task automatic next_edge();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic bus_idle();
		m1_n   = 1'b1;
		mreq_n = 1'b1;
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
	endtask

	task automatic apply_reset(input mem_mode_t mode);
		next_edge();
		bus_idle();
		mem_mode  = mode;
		reset_req = 1'b1;
		@(negedge reset);
		reset_req  = 1'b0;
		exp_mode   = mode;
		exp_bank   = '0;
		exp_rom    = (mode == MEM_48K);
		exp_scr    = 1'b0;
		exp_locked = 1'b0;
	endtask

	// Data changes after the first sampled edge, only the first value may count
	task automatic io_write_cycle(input cpu_addr_t port, input cpu_data_t data,
			input cpu_data_t late_data, input int hold);
		next_edge();
		addr     = port;
		cpu_dout = data;
		iorq_n   = 1'b0;
		wr_n     = 1'b0;
		next_edge();
		cpu_dout = late_data;
		repeat (hold - 1) next_edge();
		bus_idle();
		next_edge();
	endtask

	// Leaves the strobes active so the caller can check the response
	task automatic mem_cycle(input cpu_addr_t a, input logic write);
		next_edge();
		addr   = a;
		mreq_n = 1'b0;
		if (write) begin
			wr_n = 1'b0;
		end else begin
			rd_n = 1'b0;
		end
		#1;
	endtask

	task automatic io_read_cycle(input cpu_addr_t port, input key_matrix_t keys, input logic ear);
		next_edge();
		key_matrix = keys;
		ear_in     = ear;
		addr       = port;
		iorq_n     = 1'b0;
		rd_n       = 1'b0;
		#1;
	endtask

	task automatic page_write(input cpu_data_t d, input cpu_data_t late, input int hold);
		io_write_cycle(16'h7ffd, d, late, hold);
		if (!exp_locked && exp_mode != MEM_48K) begin
			exp_bank   = (exp_mode == MEM_512K) ? {d[7:6], d[2:0]} : {2'b00, d[2:0]};
			exp_scr    = d[3];
			exp_rom    = d[4];
			exp_locked = d[5];
		end
	endtask

	task automatic check_window(input cpu_addr_t a);
		mem_cycle(a, 1'b0);
		check_mem_addr("ram_addr", ram_addr, exp_map(a));
		check_bit("ram_rd", ram_rd, 1'b1);
		bus_idle();
	endtask

	task automatic check_page();
		cpu_addr_t a;
		a = rand_addr();
		check_bit("screen_page", screen_page, exp_scr);
		check_window({2'b00, a[13:0]});
		check_window({2'b11, a[13:0]});
	endtask

	// ========================================================================
	// Tests
	// ========================================================================

	task automatic test_reset_map();
		cpu_addr_t a;
		apply_reset(MEM_128K);
		check_bit("screen_page", screen_page, 1'b0);
		check_border("border_color", border_color, 3'd0);
		check_bit("ear_out", ear_out, 1'b0);
		check_bit("mic_out", mic_out, 1'b0);
		check_window(16'h0000);
		check_window(16'h4000);
		check_window(16'h8000);
		check_window(16'hc000);
		a = rand_addr();
		mem_cycle({2'b00, a[13:0]}, 1'b1);
		check_bit("ram_we", ram_we, 1'b0);
		bus_idle();
		mem_cycle({2'b10, a[13:0]}, 1'b1);
		check_bit("ram_we", ram_we, 1'b1);
		bus_idle();
	endtask

	task automatic test_page_write();
		cpu_data_t d;
		d = rand_byte() & 8'hdf;
		page_write(d, d ^ 8'h1f, 3);
		check_page();
		d = rand_byte() & 8'hdf;
		page_write(d, d, 1);
		check_page();
	endtask

	task automatic test_lock();
		cpu_data_t d;
		d = rand_byte() | 8'h20;
		page_write(d, d, 1);
		check_page();
		page_write(~d & 8'hdf, ~d & 8'hdf, 1);
		check_page();
		apply_reset(MEM_128K);
		check_page();
	endtask

	task automatic test_modes();
		cpu_data_t d;
		apply_reset(MEM_512K);
		d = (rand_byte() & 8'h1f) | 8'h80;
		page_write(d, d, 1);
		check_page();
		d = rand_byte() & 8'hdf;
		page_write(d, d, 2);
		check_page();
		// 48K keeps BASIC ROM and ignores the paging port
		apply_reset(MEM_48K);
		check_page();
		d = (rand_byte() & 8'hc7) | 8'h09;
		page_write(d, d, 1);
		check_page();
		apply_reset(MEM_128K);
	endtask

	task automatic test_ula_write();
		cpu_data_t d;
		int        i;
		for (i = 0; i < 3; i++) begin
			d = rand_byte();
			io_write_cycle(16'h00fe, d, ~d, 2);
			check_border("border_color", border_color, d[2:0]);
			check_bit("ear_out", ear_out, d[4]);
			check_bit("mic_out", mic_out, d[3]);
			check_page();
		end
	endtask

	task automatic test_reads();
		cpu_addr_t   a;
		key_matrix_t keys;
		logic [31:0] rnd;
		int          i;
		for (i = 0; i < 4; i++) begin
			a = rand_addr();
			mem_cycle(a, 1'b0);
			check_data("cpu_din", cpu_din, mem_model[exp_map(a)]);
			bus_idle();
		end
		for (i = 0; i < 6; i++) begin
			rnd        = $urandom;
			keys[31:0] = $urandom;
			keys[39:32] = rnd[7:0];
			a          = {rnd[23:16], 8'hfe};
			io_read_cycle(a, keys, rnd[8]);
			check_data("cpu_din", cpu_din, exp_key_byte(a, keys, rnd[8]));
			bus_idle();
		end
		// Odd ports have no device behind them
		io_read_cycle({rand_byte(), 8'hff}, keys, 1'b0);
		check_data("cpu_din", cpu_din, 8'hff);
		bus_idle();
	endtask

	initial begin
		int i;
		void'($urandom(32'hd7a7_8bad));
		reset_req  = 1'b0;
		addr       = '0;
		cpu_dout   = '0;
		mem_mode   = MEM_128K;
		key_matrix = '1;
		ear_in     = 1'b0;
		bus_idle();
		for (i = 0; i < (1 << 20); i++) begin
			mem_model[i] = i[7:0] ^ i[15:8] ^ {i[19:16], i[19:16]} ^ 8'h96;
		end
		@(negedge reset);
		test_reset_map();
		test_page_write();
		test_lock();
		test_modes();
		test_ula_write();
		test_reads();
		$display("Test OK");
		$finish;
	end

endmodule

//--- verilog.f
logic/zx_pkg.sv
logic/zx_bus_decode.sv
logic/zx_mem_pager.sv
logic/zx_ula_port.sv
logic/zx_io_read.sv
logic/zx_host_top.sv
bench/tb_clock.sv
bench/tb_zx_host.sv

//--- Bender.yml
package:
  name: zx_host

sources:
  - logic/zx_pkg.sv
  - logic/zx_bus_decode.sv
  - logic/zx_mem_pager.sv
  - logic/zx_ula_port.sv
  - logic/zx_io_read.sv
  - logic/zx_host_top.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/tb_zx_host.sv
